/* bench/tb_clk.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_clk (
  output logic clk,
  output logic rst_n
);

  localparam int RST_CYCLES = 16;

  logic clk_q = 1'b0;
  logic rst_q = 1'b0;
  int   rst_count = 0;

  assign clk   = clk_q;
  assign rst_n = rst_q;

  // 20 ns period
  initial begin
    forever #10 clk_q = ~clk_q;
  end

  // the first RST_CYCLES edges see reset low
  always @(posedge clk_q) begin
    rst_count <= rst_count + 1;
    if (rst_count == RST_CYCLES - 1) begin
      rst_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* bench/tb_tests.svh */
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// pattern built from the whole address
function automatic mem_cfg_pkg::data_t fill_word(input mem_cfg_pkg::addr_t a);
  return {8'hd0, 2'b01, a, 10'h155, a};
endfunction

task automatic expect_rsp(input mem_cfg_pkg::data_t d, input mem_cfg_pkg::padr_t p,
                          input mem_cfg_pkg::data_t ed, input mem_cfg_pkg::padr_t ep,
                          input string what);
  assert (d === ed && p === ep) else begin
    $display("MISMATCH at %0t: %s got %h at %h, expected %h at %h", $time, what, d, p, ed, ep);
    test_errs++;
  end
endtask

task automatic check_reset();
  @(negedge clk);
  while (rst_n !== 1'b1) begin
    assert (ready === 1'b0 && rsp.valid === 1'b0) else begin
      $display("ERROR at %0t: ready or rsp.valid high during reset", $time);
      test_errs++;
    end
    @(negedge clk);
  end
  // first edge with rst_n high still ahead here
  @(negedge clk);
  assert (ready === 1'b1) else begin
    $display("ERROR at %0t: ready did not rise after reset", $time);
    test_errs++;
  end
endtask

task automatic fill_and_readback();
  mem_cfg_pkg::data_t d;
  mem_cfg_pkg::padr_t p;
  for (int i = 0; i < 64; i++) begin
    issue(1'b1, mem_cfg_pkg::addr_t'(i), fill_word(mem_cfg_pkg::addr_t'(i)), 1'b0, '0);
  end
  idle();
  // identity map, pbank from the low bits and row from the high bits
  for (int i = 0; i < 64; i++) begin
    read_word(mem_cfg_pkg::addr_t'(i), d, p);
    expect_rsp(d, p, fill_word(mem_cfg_pkg::addr_t'(i)),
               {mem_cfg_pkg::pbank_t'(i % 4), mem_cfg_pkg::row_t'(i / 4)}, "readback");
  end
endtask

task automatic read_write_apart();
  mem_cfg_pkg::data_t d;
  mem_cfg_pkg::padr_t p;
  // vbank 1 and vbank 2 sit in different banks
  issue(1'b1, 6'h0a, 32'h5a5a_0a0a, 1'b1, 6'h05);
  idle();
  wait_rsp(d, p);
  expect_rsp(d, p, fill_word(6'h05), 7'h11, "parallel read");
  read_word(6'h0a, d, p);
  expect_rsp(d, p, 32'h5a5a_0a0a, 7'h22, "parallel write");
endtask

task automatic conflict_remap();
  mem_cfg_pkg::data_t  d;
  mem_cfg_pkg::padr_t  p;
  mem_cfg_pkg::pbank_t spare;
  mem_cfg_pkg::pbank_t displaced;
  spare     = free_m[10];
  displaced = map_m[10][3];
  // 0x13 and 0x2b both live in pbank 3
  issue(1'b1, 6'h2b, 32'hc0de_002b, 1'b1, 6'h13);
  idle();
  wait_rsp(d, p);
  expect_rsp(d, p, fill_word(6'h13), 7'h34, "conflict read");
  read_word(6'h2b, d, p);
  expect_rsp(d, p, 32'hc0de_002b, {spare, 4'd10}, "remapped write");
  // next conflict in row 10 takes the displaced bank
  issue(1'b1, 6'h28, 32'hc0de_0028, 1'b1, 6'h00);
  idle();
  wait_rsp(d, p);
  expect_rsp(d, p, fill_word(6'h00), 7'h00, "second conflict read");
  read_word(6'h28, d, p);
  expect_rsp(d, p, 32'hc0de_0028, {displaced, 4'd10}, "second remap");
endtask

task automatic same_address();
  mem_cfg_pkg::data_t d;
  mem_cfg_pkg::padr_t p;
  issue(1'b1, 6'h21, 32'h0bad_f00d, 1'b1, 6'h21);
  idle();
  wait_rsp(d, p);
  expect_rsp(d, p, fill_word(6'h21), 7'h18, "collision old data");
  // the write went to row 8's spare bank 4
  read_word(6'h21, d, p);
  expect_rsp(d, p, 32'h0bad_f00d, 7'h48, "collision new data");
endtask

// checked by the reference models each cycle
task automatic random_traffic(input int n);
  logic [31:0] bits;
  for (int c = 0; c < n; c++) begin
    rng  = xorshift(rng);
    bits = rng;
    rng  = xorshift(rng);
    issue(bits[0], bits[7:2], rng, bits[1], bits[13:8]);
  end
  idle();
endtask

`endif

/* bench/tb_top.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_top;

  localparam int MAX_CYCLES = 2000;

  logic                clk;
  logic                rst_n;
  mem_if_pkg::wr_cmd_t wr = '0;
  mem_if_pkg::rd_cmd_t rd = '0;
  logic                ready;
  mem_if_pkg::rd_rsp_t rsp;

  // reference models of the data and of the bank map
  mem_cfg_pkg::data_t  data_m [64];
  logic                known  [64];
  mem_cfg_pkg::pbank_t map_m  [mem_cfg_pkg::NUMVROW][mem_cfg_pkg::NUMVBNK];
  mem_cfg_pkg::pbank_t free_m [mem_cfg_pkg::NUMVROW];

  logic               exp_valid = 1'b0;
  logic               exp_known = 1'b0;
  mem_cfg_pkg::data_t exp_data;
  mem_cfg_pkg::padr_t exp_padr;

  int          model_errs = 0;
  int          proto_errs = 0;
  int          test_errs  = 0;
  int          cycles     = 0;
  logic [31:0] rng        = 32'hb4b0_fdf4;

  tb_clk u_clk (
    .clk   (clk),
    .rst_n (rst_n)
  );

  remap_1r1w_top DUT (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (wr),
    .rd    (rd),
    .ready (ready),
    .rsp   (rsp)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  // follows the accepted commands at each edge
  always @(posedge clk) begin : ref_model
    mem_cfg_pkg::pbank_t rpb;
    mem_cfg_pkg::pbank_t wpb;
    if (!rst_n) begin
      for (int r = 0; r < mem_cfg_pkg::NUMVROW; r++) begin
        for (int v = 0; v < mem_cfg_pkg::NUMVBNK; v++) begin
          map_m[r][v] = mem_cfg_pkg::pbank_t'(v);
        end
        free_m[r] = mem_cfg_pkg::pbank_t'(mem_cfg_pkg::NUMVBNK);
      end
      for (int a = 0; a < 64; a++) begin
        known[a] = 1'b0;
      end
      exp_valid = 1'b0;
    end else begin
      rpb       = map_m[rd.addr[5:2]][rd.addr[1:0]];
      wpb       = map_m[wr.addr[5:2]][wr.addr[1:0]];
      exp_valid = ready && rd.valid;
      exp_data  = data_m[rd.addr];
      exp_known = known[rd.addr];
      exp_padr  = {rpb, rd.addr[5:2]};
      if (ready && wr.valid) begin
        // a write that hits the read's bank moves to the spare
        if (exp_valid && wpb == rpb) begin
          map_m[wr.addr[5:2]][wr.addr[1:0]] = free_m[wr.addr[5:2]];
          free_m[wr.addr[5:2]] = wpb;
        end
        data_m[wr.addr] = wr.data;
        known[wr.addr]  = 1'b1;
      end
    end
  end

  always @(negedge clk) begin : rsp_check
    assert (rsp.valid === exp_valid) else begin
      if (exp_valid) begin
        $display("ERROR at %0t: read response did not arrive", $time);
      end else begin
        $display("ERROR at %0t: read response without a read", $time);
      end
      proto_errs++;
    end
    if (exp_valid && rsp.valid === 1'b1) begin
      assert (rsp.padr === exp_padr) else begin
        $display("MISMATCH at %0t: padr %h, expected %h", $time, rsp.padr, exp_padr);
        model_errs++;
      end
      assert (!exp_known || rsp.data === exp_data) else begin
        $display("MISMATCH at %0t: data %h, expected %h", $time, rsp.data, exp_data);
        model_errs++;
      end
    end
  end

  always @(posedge clk) begin : watchdog
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("ERROR: run stopped after %0d cycles without finishing", cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  task automatic issue(input logic wv, input mem_cfg_pkg::addr_t wa,
                       input mem_cfg_pkg::data_t wd, input logic rv,
                       input mem_cfg_pkg::addr_t ra);
    while (ready !== 1'b1) begin
      @(negedge clk);
    end
    @(posedge clk);
    wr.valid <= wv;
    wr.addr  <= wa;
    wr.data  <= wd;
    rd.valid <= rv;
    rd.addr  <= ra;
  endtask

  task automatic idle();
    @(posedge clk);
    wr.valid <= 1'b0;
    rd.valid <= 1'b0;
  endtask

  task automatic wait_rsp(output mem_cfg_pkg::data_t d, output mem_cfg_pkg::padr_t p);
    int n;
    n = 0;
    @(negedge clk);
    while (rsp.valid !== 1'b1 && n < 4) begin
      @(negedge clk);
      n++;
    end
    assert (rsp.valid === 1'b1) else begin
      $display("ERROR at %0t: no read response within 4 cycles", $time);
      test_errs++;
    end
    d = rsp.data;
    p = rsp.padr;
  endtask

  task automatic read_word(input mem_cfg_pkg::addr_t a, output mem_cfg_pkg::data_t d,
                           output mem_cfg_pkg::padr_t p);
    issue(1'b0, '0, '0, 1'b1, a);
    idle();
    wait_rsp(d, p);
  endtask

  `include "tb_tests.svh"

  initial begin
    check_reset();
    fill_and_readback();
    read_write_apart();
    conflict_remap();
    same_address();
    random_traffic(400);
    @(negedge clk);
    @(negedge clk);
    $display("errors: %0d model mismatches, %0d directed, %0d protocol",
             model_errs, test_errs, proto_errs);
    if (model_errs == 0 && test_errs == 0 && proto_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+bench
rtl/mem_cfg_pkg.sv
rtl/mem_if_pkg.sv
rtl/sp_bank.sv
rtl/remap_table.sv
rtl/bank_array.sv
rtl/remap_1r1w_top.sv
bench/tb_clk.sv
bench/tb_top.sv

/* rtl/bank_array.sv */
`default_nettype none
`timescale 1ns/1ps

module bank_array (
  input  logic                  clk,
  input  logic                  rst_n,
  input  mem_if_pkg::bank_req_t rd_req,
  input  mem_if_pkg::bank_req_t wr_req,
  input  mem_cfg_pkg::data_t    wr_data,
  output mem_if_pkg::rd_rsp_t   rsp
);

  mem_cfg_pkg::data_t  bank_dout [mem_cfg_pkg::NUMPBNK];
  logic                rd_vld_q;
  mem_cfg_pkg::padr_t  rd_padr_q;
  mem_cfg_pkg::pbank_t rsp_pbk;
  mem_cfg_pkg::data_t  rsp_data;

  // the table never aims both ports at one bank
  for (genvar b = 0; b < mem_cfg_pkg::NUMPBNK; b++) begin : g_bank
    logic              rd_sel;
    logic              wr_sel;
    mem_cfg_pkg::row_t bank_row;

    assign rd_sel   = rd_req.valid && (rd_req.pbank == mem_cfg_pkg::pbank_t'(b));
    assign wr_sel   = wr_req.valid && (wr_req.pbank == mem_cfg_pkg::pbank_t'(b));
    assign bank_row = wr_sel ? wr_req.row : rd_req.row;

    sp_bank u_bank (
      .clk  (clk),
      .en   (rd_sel | wr_sel),
      .we   (wr_sel),
      .row  (bank_row),
      .din  (wr_data),
      .dout (bank_dout[b])
    );
  end

  // read tag follows the bank's registered data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rd_req.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req.valid) begin
      rd_padr_q <= {rd_req.pbank, rd_req.row};
    end
  end

  assign rsp_pbk = rd_padr_q[mem_cfg_pkg::BITPADR-1:mem_cfg_pkg::BITVROW];

  // pick the addressed bank's output
  always_comb begin
    rsp_data = '0;
    for (int b = 0; b < mem_cfg_pkg::NUMPBNK; b++) begin
      if (rsp_pbk == mem_cfg_pkg::pbank_t'(b)) begin
        rsp_data = bank_dout[b];
      end
    end
  end

  always_comb begin
    rsp.valid = rd_vld_q;
    rsp.data  = rsp_data;
    rsp.padr  = rd_padr_q;
  end

endmodule

`default_nettype wire

/* rtl/mem_cfg_pkg.sv */
`default_nettype none

package mem_cfg_pkg;

  // data word
  localparam int WIDTH   = 32;

  // virtual banks come from the low address bits
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;

  // one spare physical bank beyond the virtual ones
  localparam int NUMPBNK = 5;
  localparam int BITPBNK = 3;

  // rows per bank, from the high address bits
  localparam int NUMVROW = 16;
  localparam int BITVROW = 4;

  localparam int BITADDR = BITVROW + BITVBNK;
  // pbank in the upper bits, row below it
  localparam int BITPADR = BITPBNK + BITVROW;

  typedef logic [WIDTH-1:0]   data_t;
  typedef logic [BITADDR-1:0] addr_t;
  typedef logic [BITVBNK-1:0] vbank_t;
  typedef logic [BITPBNK-1:0] pbank_t;
  typedef logic [BITVROW-1:0] row_t;
  typedef logic [BITPADR-1:0] padr_t;

endpackage

`default_nettype wire

/* rtl/mem_if_pkg.sv */
`default_nettype none

package mem_if_pkg;

  // write command, counts only while ready is high
  typedef struct packed {
    logic               valid;
    mem_cfg_pkg::addr_t addr;
    mem_cfg_pkg::data_t data;
  } wr_cmd_t;

  // read command
  typedef struct packed {
    logic               valid;
    mem_cfg_pkg::addr_t addr;
  } rd_cmd_t;

  // read response, one cycle after the accepted read
  typedef struct packed {
    logic               valid;
    mem_cfg_pkg::data_t data;
    mem_cfg_pkg::padr_t padr;
  } rd_rsp_t;

  // one port's operation on a physical bank
  typedef struct packed {
    logic                valid;
    mem_cfg_pkg::pbank_t pbank;
    mem_cfg_pkg::row_t   row;
  } bank_req_t;

endpackage

`default_nettype wire

/* rtl/remap_1r1w_top.sv */
`default_nettype none
`timescale 1ns/1ps

module remap_1r1w_top (
  input  logic                clk,
  input  logic                rst_n,
  input  mem_if_pkg::wr_cmd_t wr,
  input  mem_if_pkg::rd_cmd_t rd,
  output logic                ready,
  output mem_if_pkg::rd_rsp_t rsp
);

  // requests from the table into the banks
  mem_if_pkg::bank_req_t rd_req;
  mem_if_pkg::bank_req_t wr_req;
  mem_cfg_pkg::data_t    wr_data;

  // bank map, conflict steering and ready
  remap_table u_table (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (wr),
    .rd      (rd),
    .ready   (ready),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .wr_data (wr_data)
  );

  // physical banks and the read response
  bank_array u_banks (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_req  (rd_req),
    .wr_req  (wr_req),
    .wr_data (wr_data),
    .rsp     (rsp)
  );

endmodule

`default_nettype wire

/* rtl/remap_table.sv */
`default_nettype none
`timescale 1ns/1ps

module remap_table (
  input  logic                   clk,
  input  logic                   rst_n,
  input  mem_if_pkg::wr_cmd_t    wr,
  input  mem_if_pkg::rd_cmd_t    rd,
  output logic                   ready,
  output mem_if_pkg::bank_req_t  rd_req,
  output mem_if_pkg::bank_req_t  wr_req,
  output mem_cfg_pkg::data_t     wr_data
);

  // per row: the pbank holding each vbank, and the spare pbank
  mem_cfg_pkg::pbank_t map_q  [mem_cfg_pkg::NUMVROW][mem_cfg_pkg::NUMVBNK];
  mem_cfg_pkg::pbank_t free_q [mem_cfg_pkg::NUMVROW];

  logic                rd_go;
  logic                wr_go;
  mem_cfg_pkg::row_t   rd_row;
  mem_cfg_pkg::vbank_t rd_vbk;
  mem_cfg_pkg::row_t   wr_row;
  mem_cfg_pkg::vbank_t wr_vbk;
  mem_cfg_pkg::pbank_t rd_pbk;
  mem_cfg_pkg::pbank_t wr_map_pbk;
  mem_cfg_pkg::pbank_t wr_free_pbk;
  mem_cfg_pkg::pbank_t wr_pbk;
  logic                conflict;

  // commands count only once ready
  assign rd_go = rd.valid & ready;
  assign wr_go = wr.valid & ready;

  // address split, vbank in the low bits
  assign rd_vbk = rd.addr[mem_cfg_pkg::BITVBNK-1:0];
  assign rd_row = rd.addr[mem_cfg_pkg::BITADDR-1:mem_cfg_pkg::BITVBNK];
  assign wr_vbk = wr.addr[mem_cfg_pkg::BITVBNK-1:0];
  assign wr_row = wr.addr[mem_cfg_pkg::BITADDR-1:mem_cfg_pkg::BITVBNK];

  // lookups see the table from before this edge
  assign rd_pbk      = map_q[rd_row][rd_vbk];
  assign wr_map_pbk  = map_q[wr_row][wr_vbk];
  assign wr_free_pbk = free_q[wr_row];

  // rows may differ, only the physical bank matters
  assign conflict = rd_go & wr_go & (rd_pbk == wr_map_pbk);

  // the spare bank of the write row is never the read's bank
  assign wr_pbk = conflict ? wr_free_pbk : wr_map_pbk;

  always_comb begin
    rd_req.valid = rd_go;
    rd_req.pbank = rd_pbk;
    rd_req.row   = rd_row;
  end

  always_comb begin
    wr_req.valid = wr_go;
    wr_req.pbank = wr_pbk;
    wr_req.row   = wr_row;
  end

  assign wr_data = wr.data;

  // identity map on reset, swap with the spare on a conflict
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int r = 0; r < mem_cfg_pkg::NUMVROW; r++) begin
        for (int v = 0; v < mem_cfg_pkg::NUMVBNK; v++) begin
          map_q[r][v] <= mem_cfg_pkg::pbank_t'(v);
        end
        free_q[r] <= mem_cfg_pkg::pbank_t'(mem_cfg_pkg::NUMVBNK);
      end
    end else if (conflict) begin
      map_q[wr_row][wr_vbk] <= wr_free_pbk;
      // displaced bank becomes the row's spare
      free_q[wr_row]        <= wr_map_pbk;
    end
  end

  // up on the first edge out of reset, and stays up
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ready <= 1'b0;
    end else begin
      ready <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/sp_bank.sv */
`default_nettype none
`timescale 1ns/1ps

module sp_bank (
  input  logic               clk,
  input  logic               en,
  input  logic               we,
  input  mem_cfg_pkg::row_t  row,
  input  mem_cfg_pkg::data_t din,
  output mem_cfg_pkg::data_t dout
);

  // one word per row, single port
  mem_cfg_pkg::data_t mem [mem_cfg_pkg::NUMVROW];

  // write at the edge, or register the addressed word
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[row] <= din;
      end else begin
        dout <= mem[row];
      end
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_top -Mdir obj_dir -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "TEST PASS" sim.log && exit 0 || exit 1
